//--- common/blit_defs.svh
// Register numbers and field positions of the blitter register file.
// Include wherever a register number or a field bit is decoded.
`ifndef BLIT_DEFS_SVH
`define BLIT_DEFS_SVH

// register numbers on xreg_num_i
`define BLIT_REG_CTRL       4'd0
`define BLIT_REG_SHIFT      4'd1
`define BLIT_REG_MOD_A      4'd2
`define BLIT_REG_SRC_A      4'd3
`define BLIT_REG_MOD_B      4'd4
`define BLIT_REG_SRC_B      4'd5
`define BLIT_REG_VAL_C      4'd6
`define BLIT_REG_MOD_D      4'd7
`define BLIT_REG_DST_D      4'd8
`define BLIT_REG_LINES      4'd9
`define BLIT_REG_WORDS      4'd10       // writing this one queues the blit

// CTRL register fields
`define BLIT_CTRL_A_CONST   0
`define BLIT_CTRL_B_CONST   1
`define BLIT_CTRL_B_NOT     2
`define BLIT_CTRL_C_USE_B   3
`define BLIT_CTRL_T_MSB     15
`define BLIT_CTRL_T_LSB     8

// SHIFT register fields
`define BLIT_SHIFT_AMT_MSB  1
`define BLIT_SHIFT_AMT_LSB  0
`define BLIT_SHIFT_LM_MSB   11
`define BLIT_SHIFT_LM_LSB   8
`define BLIT_SHIFT_FM_MSB   15
`define BLIT_SHIFT_FM_LSB   12

`define BLIT_LINES_W        15          // line count width

`endif

//--- common/blit_pkg.sv
// Types shared by the blitter blocks and the testbench.
// Compile before any blitter module.
`include "blit_defs.svh"

package blit_pkg;

    typedef logic [15:0] word_t;
    typedef logic [15:0] addr_t;

    // control and shift fields of one blit
    typedef struct packed {
        logic           a_const;
        logic           b_const;
        logic           b_not;
        logic           c_use_b;
        logic [7:0]     transp_t;       // two transparency nibbles
        logic [1:0]     shift;          // right shift in nibbles
        logic [3:0]     f_mask;         // first word nibble mask
        logic [3:0]     l_mask;         // last word nibble mask
    } blit_ctrl_t;

    // complete blit description as held in the register file
    typedef struct packed {
        blit_ctrl_t                 ctrl;
        addr_t                      src_a;
        word_t                      mod_a;
        addr_t                      src_b;
        word_t                      mod_b;
        word_t                      val_c;
        addr_t                      dst_d;
        word_t                      mod_d;
        logic [`BLIT_LINES_W-1:0]   lines;      // line count minus one
        word_t                      words;      // word count minus one
    } blit_cfg_t;

    typedef struct packed {
        logic           sel;
        logic           wr;
        addr_t          addr;
        word_t          data;
        logic [3:0]     mask;           // nibble write enables
    } vram_req_t;

    typedef enum logic [2:0] {
        IDLE, SETUP, LINE_BEG, WAIT_RD_A, WAIT_RD_B, WAIT_WR_D, LINE_END
    } seq_state_t;

endpackage

//--- blitter/blit_regs.sv
// Blitter register file.
// Holds the next blit while the current one runs; a WORDS write queues it
// and the sequencer's take pulse releases the slot.
`timescale 1ns/1ps
`include "blit_defs.svh"

module blit_regs (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                xreg_wr_en_i,
    input  logic [3:0]          xreg_num_i,
    input  blit_pkg::word_t     xreg_data_i,
    input  logic                take_i,
    output blit_pkg::blit_cfg_t cfg_o,
    output logic                queued_o
);
    import blit_pkg::*;

    blit_cfg_t  cfg_q;
    logic       queued_q;

    assign cfg_o    = cfg_q;
    assign queued_o = queued_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cfg_q    <= '0;
            queued_q <= 1'b0;
        end else begin
            if (take_i) begin
                queued_q <= 1'b0;               // sequencer copied the blit
            end
            if (xreg_wr_en_i) begin
                case (xreg_num_i)
                    `BLIT_REG_CTRL: begin
                        cfg_q.ctrl.a_const  <= xreg_data_i[`BLIT_CTRL_A_CONST];
                        cfg_q.ctrl.b_const  <= xreg_data_i[`BLIT_CTRL_B_CONST];
                        cfg_q.ctrl.b_not    <= xreg_data_i[`BLIT_CTRL_B_NOT];
                        cfg_q.ctrl.c_use_b  <= xreg_data_i[`BLIT_CTRL_C_USE_B];
                        cfg_q.ctrl.transp_t <= xreg_data_i[`BLIT_CTRL_T_MSB:`BLIT_CTRL_T_LSB];
                    end
                    `BLIT_REG_SHIFT: begin
                        cfg_q.ctrl.shift  <= xreg_data_i[`BLIT_SHIFT_AMT_MSB:`BLIT_SHIFT_AMT_LSB];
                        cfg_q.ctrl.l_mask <= xreg_data_i[`BLIT_SHIFT_LM_MSB:`BLIT_SHIFT_LM_LSB];
                        cfg_q.ctrl.f_mask <= xreg_data_i[`BLIT_SHIFT_FM_MSB:`BLIT_SHIFT_FM_LSB];
                    end
                    `BLIT_REG_MOD_A: begin
                        cfg_q.mod_a <= xreg_data_i;
                    end
                    `BLIT_REG_SRC_A: begin
                        cfg_q.src_a <= xreg_data_i;
                    end
                    `BLIT_REG_MOD_B: begin
                        cfg_q.mod_b <= xreg_data_i;
                    end
                    `BLIT_REG_SRC_B: begin
                        cfg_q.src_b <= xreg_data_i;
                    end
                    `BLIT_REG_VAL_C: begin
                        cfg_q.val_c <= xreg_data_i;
                    end
                    `BLIT_REG_MOD_D: begin
                        cfg_q.mod_d <= xreg_data_i;
                    end
                    `BLIT_REG_DST_D: begin
                        cfg_q.dst_d <= xreg_data_i;
                    end
                    `BLIT_REG_LINES: begin
                        cfg_q.lines <= xreg_data_i[`BLIT_LINES_W-1:0];
                    end
                    `BLIT_REG_WORDS: begin
                        cfg_q.words <= xreg_data_i;
                        queued_q    <= 1'b1;    // wins over a take in the same cycle
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

//--- blitter/blit_sequencer.sv
// Blitter sequencer.
// Walks the rectangle line by line, issues the A/B reads and the D write of
// every word over the VRAM sel/ack handshake and signals the end of a blit.
`timescale 1ns/1ps
`include "blit_defs.svh"

module blit_sequencer (
    input  logic                    clk,
    input  logic                    reset_i,
    input  blit_pkg::blit_cfg_t     cfg_i,
    input  logic                    queued_i,
    input  logic                    vram_ack_i,
    output logic                    take_o,
    output blit_pkg::seq_state_t    state_o,
    output logic                    line_start_o,
    output logic                    first_word_o,
    output logic                    last_word_o,
    output logic                    busy_o,
    output logic                    done_intr_o,
    output logic                    sel_o,
    output logic                    wr_o,
    output blit_pkg::addr_t         addr_o,
    output blit_pkg::blit_ctrl_t    ctrl_o,
    output blit_pkg::word_t         val_c_o
);
    import blit_pkg::*;

    seq_state_t             state_q, state_n, word_state;
    blit_ctrl_t             ctrl_q;
    addr_t                  src_a_q, src_b_q, dst_d_q;
    addr_t                  src_a_n, src_b_n, dst_d_n;
    addr_t                  addr_q;
    word_t                  mod_a_q, mod_b_q, mod_d_q, val_c_q, words_q;
    logic [`BLIT_LINES_W:0] lines_q;            // top bit is the underflow flag
    logic [16:0]            count_q;            // words left in the line, same scheme
    logic                   last_line;
    logic                   first_q, done_q, sel_q, wr_q;

    assign last_line    = lines_q[`BLIT_LINES_W];
    assign last_word_o  = count_q[16];
    assign first_word_o = first_q;
    assign take_o       = (state_q == SETUP);
    assign line_start_o = (state_q == LINE_BEG);
    assign busy_o       = (state_q != IDLE);
    assign state_o      = state_q;
    assign done_intr_o  = done_q;
    assign sel_o        = sel_q;
    assign wr_o         = wr_q;
    assign addr_o       = addr_q;
    assign ctrl_o       = ctrl_q;
    assign val_c_o      = val_c_q;

    always_comb begin
        if (!ctrl_q.a_const) begin              // first access of a word
            word_state = WAIT_RD_A;
        end else if (!ctrl_q.b_const) begin
            word_state = WAIT_RD_B;
        end else begin
            word_state = WAIT_WR_D;
        end
    end

    always_comb begin
        state_n = state_q;
        src_a_n = src_a_q;
        src_b_n = src_b_q;
        dst_d_n = dst_d_q;
        case (state_q)
            IDLE: begin
                if (queued_i) state_n = SETUP;
            end
            SETUP: begin
                src_a_n = cfg_i.src_a;
                src_b_n = cfg_i.src_b;
                dst_d_n = cfg_i.dst_d;
                state_n = LINE_BEG;
            end
            LINE_BEG: state_n = word_state;
            WAIT_RD_A: begin
                if (vram_ack_i) begin
                    src_a_n = src_a_q + 16'd1;
                    state_n = ctrl_q.b_const ? WAIT_WR_D : WAIT_RD_B;
                end
            end
            WAIT_RD_B: begin
                if (vram_ack_i) begin
                    src_b_n = src_b_q + 16'd1;
                    state_n = WAIT_WR_D;
                end
            end
            WAIT_WR_D: begin
                if (vram_ack_i) begin
                    dst_d_n = dst_d_q + 16'd1;
                    state_n = last_word_o ? LINE_END : word_state;
                end
            end
            LINE_END: begin
                src_a_n = src_a_q + mod_a_q;    // step to the next line
                src_b_n = src_b_q + mod_b_q;
                dst_d_n = dst_d_q + mod_d_q;
                if (!last_line) begin
                    state_n = LINE_BEG;
                end else begin
                    state_n = queued_i ? SETUP : IDLE;
                end
            end
            default: state_n = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
            ctrl_q  <= '0;
            lines_q <= '0;
            count_q <= '0;
            first_q <= 1'b0;
            done_q  <= 1'b0;
            sel_q   <= 1'b0;
            wr_q    <= 1'b0;
            addr_q  <= '0;
        end else begin
            state_q <= state_n;
            done_q  <= (state_q == LINE_END) && last_line;
            sel_q   <= (state_n == WAIT_RD_A) || (state_n == WAIT_RD_B) ||
                       (state_n == WAIT_WR_D);
            wr_q    <= (state_n == WAIT_WR_D);
            case (state_n)                      // stays put while an ack is awaited
                WAIT_RD_A: addr_q <= src_a_n;
                WAIT_RD_B: addr_q <= src_b_n;
                default:   addr_q <= dst_d_n;
            endcase
            if (state_q == SETUP) begin
                ctrl_q  <= cfg_i.ctrl;
                lines_q <= {1'b0, cfg_i.lines};
            end
            if (state_q == LINE_BEG) begin
                lines_q <= lines_q - 1'b1;
                count_q <= {1'b0, words_q} - 17'd1;
                first_q <= 1'b1;
            end
            if ((state_q == WAIT_WR_D) && vram_ack_i) begin
                count_q <= count_q - 17'd1;
                first_q <= 1'b0;
            end
        end
    end

    // working addresses and the per-blit modulo and constant values
    always_ff @(posedge clk) begin
        src_a_q <= src_a_n;
        src_b_q <= src_b_n;
        dst_d_q <= dst_d_n;
        if (state_q == SETUP) begin
            mod_a_q <= cfg_i.mod_a;
            mod_b_q <= cfg_i.mod_b;
            mod_d_q <= cfg_i.mod_d;
            val_c_q <= cfg_i.val_c;
            words_q <= cfg_i.words;
        end
    end

endmodule

//--- blitter/blit_shifter.sv
// Right nibble shifter for one blitter source.
// Rotates the read word by 0 to 3 nibbles and fills the top from the word
// read before it, which is cleared at the start of each blit.
`timescale 1ns/1ps

module blit_shifter (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                clear_i,
    input  logic                load_i,
    input  logic [1:0]          shift_i,
    input  blit_pkg::word_t     data_i,
    output blit_pkg::word_t     shifted_o
);
    import blit_pkg::*;

    word_t prev_q;                              // previous word of this source

    always_ff @(posedge clk) begin
        if (reset_i || clear_i) begin
            prev_q <= '0;
        end else if (load_i) begin
            prev_q <= data_i;
        end
    end

    always_comb begin
        case (shift_i)
            2'd0:    shifted_o = data_i;
            2'd1:    shifted_o = {prev_q[3:0], data_i[15:4]};
            2'd2:    shifted_o = {prev_q[7:0], data_i[15:8]};
            default: shifted_o = {prev_q[11:0], data_i[15:12]};
        endcase
    end

endmodule

//--- blitter/blit_datapath.sv
// Blitter datapath.
// Keeps the A, B and C operands of the current word and forms the write
// data D = A AND B' XOR C together with its nibble write mask.
`timescale 1ns/1ps

module blit_datapath (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    start_i,
    input  logic                    line_start_i,
    input  logic                    load_a_i,
    input  logic                    load_b_i,
    input  blit_pkg::blit_ctrl_t    ctrl_i,
    input  blit_pkg::addr_t         cfg_src_a_i,
    input  blit_pkg::addr_t         cfg_src_b_i,
    input  blit_pkg::word_t         val_c_i,
    input  blit_pkg::word_t         a_shifted_i,
    input  blit_pkg::word_t         b_shifted_i,
    input  logic                    first_word_i,
    input  logic                    last_word_i,
    output blit_pkg::word_t         data_o,
    output logic [3:0]              mask_o
);
    import blit_pkg::*;

    word_t      val_a_q, val_b_q, c_eff_q, b_eff;
    logic [3:0] t_res_q;                        // nibbles that differ from T

    function automatic logic [3:0] transp_test(input word_t b, input logic [7:0] t);
        return {b[15:12] != t[7:4], b[11:8] != t[3:0], b[7:4] != t[7:4], b[3:0] != t[3:0]};
    endfunction

    always_ff @(posedge clk) begin
        if (start_i) begin                      // source registers double as constants
            val_a_q <= cfg_src_a_i;
            val_b_q <= cfg_src_b_i;
        end
        if (load_a_i) val_a_q <= a_shifted_i;
        if (line_start_i) c_eff_q <= ctrl_i.c_use_b ? val_b_q : val_c_i;
        if (load_b_i) begin
            val_b_q <= b_shifted_i;
            if (ctrl_i.c_use_b) c_eff_q <= b_shifted_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            t_res_q <= '0;
        end else if (load_b_i) begin
            t_res_q <= transp_test(b_shifted_i, ctrl_i.transp_t);
        end else if (line_start_i) begin
            t_res_q <= transp_test(val_b_q, ctrl_i.transp_t);   // constant B case
        end
    end

    assign b_eff  = ctrl_i.b_not ? ~val_b_q : val_b_q;
    assign data_o = (val_a_q & b_eff) ^ c_eff_q;
    assign mask_o = t_res_q & (first_word_i ? ctrl_i.f_mask : 4'hF) &
                    (last_word_i ? ctrl_i.l_mask : 4'hF);

endmodule

//--- blitter/blitter.sv
// VRAM blitter top level.
// Connects the register file, the sequencer, the A and B shifters and the
// datapath, and presents one VRAM request port.
`timescale 1ns/1ps

module blitter (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                xreg_wr_en_i,
    input  logic [3:0]          xreg_num_i,
    input  blit_pkg::word_t     xreg_data_i,
    input  logic                vram_ack_i,
    input  blit_pkg::word_t     vram_data_i,
    output blit_pkg::vram_req_t vram_req_o,
    output logic                busy_o,
    output logic                full_o,
    output logic                done_intr_o
);
    import blit_pkg::*;

    blit_cfg_t      cfg;
    blit_ctrl_t     ctrl;
    seq_state_t     seq_state;
    addr_t          addr;
    word_t          val_c;
    word_t          a_shifted;
    word_t          b_shifted;
    logic           queued;
    logic           take;
    logic           line_start;
    logic           first_word;
    logic           last_word;
    logic           load_a;
    logic           load_b;

    // read data returns in the ack cycle of the matching wait state
    assign load_a = vram_ack_i && (seq_state == WAIT_RD_A);
    assign load_b = vram_ack_i && (seq_state == WAIT_RD_B);

    assign full_o          = queued;
    assign vram_req_o.addr = addr;

    blit_regs u_regs (
        .clk, .reset_i, .xreg_wr_en_i, .xreg_num_i, .xreg_data_i,
        .take_i(take), .cfg_o(cfg), .queued_o(queued)
    );

    blit_sequencer u_seq (
        .clk, .reset_i, .cfg_i(cfg), .queued_i(queued), .vram_ack_i,
        .take_o(take), .state_o(seq_state), .line_start_o(line_start),
        .first_word_o(first_word), .last_word_o(last_word), .busy_o, .done_intr_o,
        .sel_o(vram_req_o.sel), .wr_o(vram_req_o.wr), .addr_o(addr),
        .ctrl_o(ctrl), .val_c_o(val_c)
    );

    blit_shifter u_shift_a (
        .clk, .reset_i, .clear_i(take), .load_i(load_a), .shift_i(ctrl.shift),
        .data_i(vram_data_i), .shifted_o(a_shifted)
    );

    blit_shifter u_shift_b (
        .clk, .reset_i, .clear_i(take), .load_i(load_b), .shift_i(ctrl.shift),
        .data_i(vram_data_i), .shifted_o(b_shifted)
    );

    blit_datapath u_dp (
        .clk, .reset_i, .start_i(take), .line_start_i(line_start),
        .load_a_i(load_a), .load_b_i(load_b), .ctrl_i(ctrl),
        .cfg_src_a_i(cfg.src_a), .cfg_src_b_i(cfg.src_b), .val_c_i(val_c),
        .a_shifted_i(a_shifted), .b_shifted_i(b_shifted),
        .first_word_i(first_word), .last_word_i(last_word),
        .data_o(vram_req_o.data), .mask_o(vram_req_o.mask)
    );

endmodule

//--- sim/vram_model.sv
// Testbench VRAM for the blitter, 256 words filled with random data at reset.
// Acknowledges each request after 0 to 3 random cycles; read data is valid in
// the ack cycle and a write lands on the ack edge under its nibble mask.
`timescale 1ns/1ps

module vram_model #(
    parameter int SEED = 32'hadda
) (
    input  logic                clk,
    input  logic                reset_i,
    input  blit_pkg::vram_req_t req_i,
    output logic                ack_o,
    output blit_pkg::word_t     data_o
);
    import blit_pkg::*;

    word_t      mem [256];                      // read by the testbench
    int         seed = SEED;
    logic [1:0] wait_q;                         // cycles left before the ack

    assign ack_o  = req_i.sel && (wait_q == 2'd0);
    assign data_o = mem[req_i.addr[7:0]];

    always @(posedge clk) begin : access
        logic [31:0] draw;
        if (reset_i) begin
            for (int k = 0; k < 256; k++) begin
                draw = $random(seed);
                mem[k] <= draw[15:0];
            end
            wait_q <= 2'd0;
        end else if (req_i.sel) begin
            if (wait_q == 2'd0) begin
                if (req_i.wr) begin
                    for (int n = 0; n < 4; n++) begin
                        if (req_i.mask[n]) mem[req_i.addr[7:0]][4*n +: 4] <= req_i.data[4*n +: 4];
                    end
                end
                draw = $random(seed);
                wait_q <= draw[1:0];            // latency of the next access
            end else begin
                wait_q <= wait_q - 2'd1;
            end
        end
    end

endmodule

//--- sim/tb_blitter.sv
// Testbench for the VRAM blitter.
// Runs a table of blits against the random-latency VRAM model and compares the
// whole memory with a reference model after each blit or back-to-back pair.
`timescale 1ns/1ps
`include "blit_defs.svh"

module tb_blitter;
    import blit_pkg::*;

    localparam int NUM_BLITS = 6;

    // register values of one blit, plus whether the next one is queued behind it
    typedef struct packed {
        word_t ctrl, shift, mod_a, src_a, mod_b, src_b, val_c, mod_d, dst_d, lines, words;
        logic  queue_next;
        word_t exp_writes;                      // (lines + 1) * (words + 1)
    } blit_entry_t;

    blit_entry_t blits [NUM_BLITS] = '{
        '{16'h0002, 16'hFF00, 16'd4, 16'h10, 16'd0, 16'hFFFF, 16'h0000, 16'd2, 16'h80,
          16'd2, 16'd3, 1'b0, 16'd12},
        '{16'h7707, 16'hFF00, 16'd0, 16'h5A3C, 16'd0, 16'h0FF0, 16'h1234, 16'd1, 16'hA0,
          16'd1, 16'd2, 1'b0, 16'd6},
        '{16'h880B, 16'hFF00, 16'd0, 16'h3C3C, 16'd0, 16'hF0A5, 16'h0000, 16'd0, 16'hB0,
          16'd0, 16'd5, 1'b0, 16'd6},
        '{16'h0002, 16'hBD01, 16'd0, 16'h30, 16'd0, 16'hFFFF, 16'h0000, 16'd3, 16'hC0,
          16'd1, 16'd2, 1'b0, 16'd6},
        '{16'h3C04, 16'hF703, 16'd1, 16'h40, 16'd2, 16'h50, 16'hFFFF, 16'd0, 16'hD0,
          16'd3, 16'd2, 1'b1, 16'd12},
        '{16'h0008, 16'hEF02, 16'd0, 16'h60, 16'd0, 16'h70, 16'h0000, 16'd4, 16'hE0,
          16'd1, 16'd3, 1'b0, 16'd8}
    };

    logic       clk, reset_i, xreg_wr_en, vram_ack, busy, full, done_intr;
    logic [3:0] xreg_num;
    word_t      xreg_data, vram_rdata;
    vram_req_t  vram_req;
    word_t      exp_mem [256];
    word_t      done_count = '0;
    word_t      write_count = '0;
    logic       busy_at_done = 1'b0;

    blitter DUT (
        .clk, .reset_i, .xreg_wr_en_i(xreg_wr_en), .xreg_num_i(xreg_num),
        .xreg_data_i(xreg_data), .vram_ack_i(vram_ack), .vram_data_i(vram_rdata),
        .vram_req_o(vram_req), .busy_o(busy), .full_o(full), .done_intr_o(done_intr)
    );

    vram_model #(.SEED(32'hadda)) vram (
        .clk, .reset_i, .req_i(vram_req), .ack_o(vram_ack), .data_o(vram_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (done_intr) begin
            done_count   <= done_count + 16'd1;
            busy_at_done <= busy;               // only a queued blit keeps busy up here
        end
        if (vram_req.sel && vram_req.wr && vram_ack) write_count <= write_count + 16'd1;
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "word compare failed");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "flag compare failed");
        end
    endtask

    task automatic write_reg(input logic [3:0] num, input word_t data);
        xreg_wr_en <= 1'b1;
        xreg_num   <= num;
        xreg_data  <= data;
        @(posedge clk);
        xreg_wr_en <= 1'b0;
    endtask

    // writes all registers, WORDS last, and sees the blit queued
    task automatic program_blit(input blit_entry_t e);
        write_reg(`BLIT_REG_CTRL, e.ctrl);
        write_reg(`BLIT_REG_SHIFT, e.shift);
        write_reg(`BLIT_REG_MOD_A, e.mod_a);
        write_reg(`BLIT_REG_SRC_A, e.src_a);
        write_reg(`BLIT_REG_MOD_B, e.mod_b);
        write_reg(`BLIT_REG_SRC_B, e.src_b);
        write_reg(`BLIT_REG_VAL_C, e.val_c);
        write_reg(`BLIT_REG_MOD_D, e.mod_d);
        write_reg(`BLIT_REG_DST_D, e.dst_d);
        write_reg(`BLIT_REG_LINES, e.lines);
        write_reg(`BLIT_REG_WORDS, e.words);
        @(posedge clk);
        check_flag("full_o", full, 1'b1);
    endtask

    // new word shifted right by amt nibbles, saved word entering at the top
    function automatic word_t nibble_shift(input word_t cur, input word_t prev, input int amt);
        logic [31:0] pair;
        pair = {prev, cur};
        return pair[4*amt +: 16];
    endfunction

    task automatic model_blit(input blit_entry_t e);
        word_t      a_val, b_val, c_val, d_val, a_prev, b_prev;
        addr_t      pa, pb, pd;
        logic [7:0] t;
        logic [3:0] fm, lm, t_nib;
        int         amt;
        a_val  = e.src_a;                       // constants come from the source registers
        b_val  = e.src_b;
        a_prev = '0;
        b_prev = '0;
        pa     = e.src_a;
        pb     = e.src_b;
        pd     = e.dst_d;
        t      = e.ctrl[`BLIT_CTRL_T_MSB:`BLIT_CTRL_T_LSB];
        fm     = e.shift[`BLIT_SHIFT_FM_MSB:`BLIT_SHIFT_FM_LSB];
        lm     = e.shift[`BLIT_SHIFT_LM_MSB:`BLIT_SHIFT_LM_LSB];
        amt    = int'(e.shift[`BLIT_SHIFT_AMT_MSB:`BLIT_SHIFT_AMT_LSB]);
        for (int ln = 0; ln <= int'(e.lines); ln++) begin
            for (int w = 0; w <= int'(e.words); w++) begin
                if (!e.ctrl[`BLIT_CTRL_A_CONST]) begin
                    a_val  = nibble_shift(exp_mem[pa[7:0]], a_prev, amt);
                    a_prev = exp_mem[pa[7:0]];
                    pa     = pa + 16'd1;
                end
                if (!e.ctrl[`BLIT_CTRL_B_CONST]) begin
                    b_val  = nibble_shift(exp_mem[pb[7:0]], b_prev, amt);
                    b_prev = exp_mem[pb[7:0]];
                    pb     = pb + 16'd1;
                end
                c_val = e.ctrl[`BLIT_CTRL_C_USE_B] ? b_val : e.val_c;
                d_val = (a_val & (e.ctrl[`BLIT_CTRL_B_NOT] ? ~b_val : b_val)) ^ c_val;
                for (int n = 0; n < 4; n++) begin
                    t_nib = n[0] ? t[7:4] : t[3:0];
                    if ((b_val[4*n +: 4] != t_nib) && (w != 0 || fm[n]) &&
                        (w != int'(e.words) || lm[n])) begin
                        exp_mem[pd[7:0]][4*n +: 4] = d_val[4*n +: 4];
                    end
                end
                pd = pd + 16'd1;
            end
            pa = pa + e.mod_a;                  // line step
            pb = pb + e.mod_b;
            pd = pd + e.mod_d;
        end
    endtask

    task automatic compare_memory();
        for (int k = 0; k < 256; k++) begin
            check_word($sformatf("vram[%02h]", k), vram.mem[k], exp_mem[k]);
        end
    endtask

    // budget of four cycles per access, three accesses per word
    initial begin : watchdog
        int cycles;
        cycles = 200;
        for (int k = 0; k < NUM_BLITS; k++) begin
            cycles += (int'(blits[k].lines) + 1) * (int'(blits[k].words) + 1) * 3 * 4;
        end
        repeat (cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles with blits still pending", cycles);
        $display("*** FAILED ***");
        $fatal(1, "timeout");
    end

    initial begin
        word_t n_done;
        word_t n_writes;
        int    i;
        reset_i    = 1'b1;
        xreg_wr_en = 1'b0;
        xreg_num   = '0;
        xreg_data  = '0;
        repeat (2) @(posedge clk);
        reset_i <= 1'b0;
        @(posedge clk);
        check_flag("busy_o", busy, 1'b0);
        check_flag("full_o", full, 1'b0);
        check_flag("vram_req_o.sel", vram_req.sel, 1'b0);
        n_done   = '0;
        n_writes = '0;
        i        = 0;
        while (i < NUM_BLITS) begin
            for (int k = 0; k < 256; k++) exp_mem[k] = vram.mem[k];
            program_blit(blits[i]);
            model_blit(blits[i]);
            n_done   = n_done + 16'd1;
            n_writes = n_writes + blits[i].exp_writes;
            if (blits[i].queue_next) begin
                while (full) @(posedge clk);    // first blit taken, now queue the next
                i = i + 1;
                program_blit(blits[i]);
                check_flag("busy_o", busy, 1'b1);
                while (full) @(posedge clk);
                check_flag("busy_o at done_intr_o", busy_at_done, 1'b1);   // went straight to SETUP
                check_word("done_intr_o pulses", done_count, n_done);
                model_blit(blits[i]);
                n_done   = n_done + 16'd1;
                n_writes = n_writes + blits[i].exp_writes;
            end
            while (done_count != n_done) @(posedge clk);
            repeat (3) @(posedge clk);
            check_word("done_intr_o pulses", done_count, n_done);
            check_flag("busy_o at done_intr_o", busy_at_done, 1'b0);
            check_flag("busy_o", busy, 1'b0);
            check_flag("full_o", full, 1'b0);
            check_word("vram write count", write_count, n_writes);
            compare_memory();
            i = i + 1;
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- blitter.f
+incdir+common
common/blit_pkg.sv
blitter/blit_regs.sv
blitter/blit_sequencer.sv
blitter/blit_shifter.sv
blitter/blit_datapath.sv
blitter/blitter.sv
sim/vram_model.sv
sim/tb_blitter.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the blitter testbench with Verilator and runs it.
# The script's exit status is the simulation's; a failing check ends in $fatal.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_blitter \
    -f blitter.f \
    -Mdir obj_dir

./obj_dir/Vtb_blitter
